//--- common/rot_defines.svh
// Build-time sizes for the rotation unit, included by the package and any file that needs them.
`ifndef ROT_DEFINES_SVH
`define ROT_DEFINES_SVH

// Data word width.
`define ROT_WIDTH 16

// Rotate-amount width, log2 of the word width.
`define ROT_AMT_W 4

// Result FIFO entries, also the number of command credits.
`define ROT_FIFO_DEPTH 8

`endif

//--- common/rot_pkg.sv
// Shared data types for the rotation unit, imported by every RTL module.
`include "rot_defines.svh"

package rot_pkg;

    // One data word as it passes through the unit.
    typedef logic [`ROT_WIDTH-1:0] rot_word_t;

    // Rotate amount, 0 up to width minus one.
    typedef logic [`ROT_AMT_W-1:0] rot_amt_t;

    // Rotate direction as carried on the command port.
    typedef enum logic {
        ROT_RIGHT = 1'b0,
        ROT_LEFT  = 1'b1
    } rot_dir_e;

endpackage

//--- rotator/rot_pipe.sv
// Five-stage pipelined rotator, one entry per cycle and a fixed latency of five clocks.
`timescale 1ns/1ps

module rot_pipe (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  rot_pkg::rot_word_t in_data,
    input  rot_pkg::rot_amt_t  in_amt,
    input  rot_pkg::rot_dir_e  in_dir,
    output logic               out_valid,
    output rot_pkg::rot_word_t out_data
);
    import rot_pkg::*;

    localparam int W = $bits(rot_word_t);

    // Rotate a word by a fixed step in the given direction.
    function automatic rot_word_t rot_step(rot_word_t w, rot_dir_e dir, int unsigned k);
        if (dir == ROT_LEFT) begin
            return (w << k) | (w >> (W - k));
        end
        return (w >> k) | (w << (W - k));
    endfunction

    logic      s0_valid, s1_valid, s2_valid, s3_valid;
    rot_word_t s0_data, s1_data, s2_data, s3_data;
    rot_amt_t  s0_amt, s1_amt, s2_amt;
    rot_dir_e  s0_dir, s1_dir, s2_dir;
    logic      s3_rot8;                         // Only the top amount bit is left.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s0_valid <= 1'b0;
            s0_data  <= '0;
            s0_amt   <= '0;
            s0_dir   <= ROT_RIGHT;
        end else begin
            s0_valid <= in_valid;
            s0_data  <= in_data;
            s0_amt   <= in_amt;
            s0_dir   <= in_dir;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_data  <= '0;
            s1_amt   <= '0;
            s1_dir   <= ROT_RIGHT;
        end else begin
            s1_valid <= s0_valid;
            s1_data  <= s0_amt[0] ? rot_step(s0_data, s0_dir, 1) : s0_data;
            s1_amt   <= s0_amt;
            s1_dir   <= s0_dir;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
            s2_data  <= '0;
            s2_amt   <= '0;
            s2_dir   <= ROT_RIGHT;
        end else begin
            s2_valid <= s1_valid;
            s2_data  <= s1_amt[1] ? rot_step(s1_data, s1_dir, 2) : s1_data;
            s2_amt   <= s1_amt;
            s2_dir   <= s1_dir;
        end
    end

    // Direction is dropped after this stage.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s3_valid <= 1'b0;
            s3_data  <= '0;
            s3_rot8  <= 1'b0;
        end else begin
            s3_valid <= s2_valid;
            s3_data  <= s2_amt[2] ? rot_step(s2_data, s2_dir, 4) : s2_data;
            s3_rot8  <= s2_amt[3];
        end
    end

    // Half-word rotate, same result left or right.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= s3_valid;
            out_data  <= s3_rot8 ? rot_step(s3_data, ROT_LEFT, 8) : s3_data;
        end
    end

endmodule

//--- rotator/rot_cmd_rx.sv
// Four-phase command receiver that spends a FIFO credit for each command it feeds to the rotator.
`timescale 1ns/1ps
`include "rot_defines.svh"

module rot_cmd_rx (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cmd_req,
    input  rot_pkg::rot_word_t cmd_data,
    input  rot_pkg::rot_amt_t  cmd_amt,
    input  rot_pkg::rot_dir_e  cmd_dir,
    output logic               cmd_ack,
    input  logic               credit_ret,
    output logic               in_valid,
    output rot_pkg::rot_word_t in_data,
    output rot_pkg::rot_amt_t  in_amt,
    output rot_pkg::rot_dir_e  in_dir
);
    localparam int CRED_W = $clog2(`ROT_FIFO_DEPTH + 1);

    typedef enum logic {
        RX_IDLE,
        RX_ACKED
    } rx_state_e;

    rx_state_e         state_q;
    logic [CRED_W-1:0] credits_q;
    logic              take;

    // Accept only with room left in the result FIFO.
    assign take    = (state_q == RX_IDLE) && cmd_req && (credits_q != '0);
    assign cmd_ack = (state_q == RX_ACKED);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= RX_IDLE;
            in_valid <= 1'b0;
        end else begin
            in_valid <= take;                   // One-cycle pipeline entry.
            case (state_q)
                RX_IDLE:  if (take) state_q <= RX_ACKED;
                RX_ACKED: if (!cmd_req) state_q <= RX_IDLE;
                default:  state_q <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits_q <= CRED_W'(`ROT_FIFO_DEPTH);
        end else if (take && !credit_ret) begin
            credits_q <= credits_q - 1'b1;
        end else if (!take && credit_ret) begin
            credits_q <= credits_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            in_data <= cmd_data;
            in_amt  <= cmd_amt;
            in_dir  <= cmd_dir;
        end
    end

endmodule

//--- rtl/rot_result_fifo.sv
// In-order result FIFO between the rotator output and the result sender.
`timescale 1ns/1ps
`include "rot_defines.svh"

module rot_result_fifo (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  rot_pkg::rot_word_t wr_data,
    input  logic               pop,
    output rot_pkg::rot_word_t rd_data,
    output logic               empty
);
    import rot_pkg::*;

    localparam int DEPTH = `ROT_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    rot_word_t         mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr, rd_ptr;
    logic [CNT_W-1:0]  count, count_next;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_comb begin
        count_next = count;
        if (wr_en && !pop) begin
            count_next = count + 1'b1;
        end else if (!wr_en && pop) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            empty  <= 1'b1;
        end else begin
            if (wr_en) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            count <= count_next;
            empty <= (count_next == '0);        // Registered flag.
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    assign rd_data = mem[rd_ptr];               // Oldest word.

endmodule

//--- rtl/rot_result_tx.sv
// Four-phase result sender that hands the FIFO head to the host and returns a credit per word.
`timescale 1ns/1ps

module rot_result_tx (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               empty,
    input  rot_pkg::rot_word_t rd_data,
    output logic               pop,
    output logic               credit_ret,
    output logic               res_req,
    output rot_pkg::rot_word_t res_data,
    input  logic               res_ack
);
    logic pop_q;
    logic taken;
    logic start;

    assign taken = res_req && res_ack;

    // The empty flag lags a pop by one clock, so skip the cycle of the pop.
    assign start = !res_req && !res_ack && !empty && !pop_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_req <= 1'b0;
            pop_q   <= 1'b0;
        end else begin
            pop_q <= taken;
            if (taken) begin
                res_req <= 1'b0;
            end else if (start) begin
                res_req <= 1'b1;
            end
        end
    end

    assign pop        = pop_q;
    assign credit_ret = pop_q;                  // One credit per delivered word.

    // Head of the FIFO holds still until the pop.
    assign res_data = rd_data;

endmodule

//--- rtl/rot_unit_top.sv
// Top level of the rotation unit with the command and result req/ack ports.
`timescale 1ns/1ps

module rot_unit_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cmd_req,
    input  rot_pkg::rot_word_t cmd_data,
    input  rot_pkg::rot_amt_t  cmd_amt,
    input  rot_pkg::rot_dir_e  cmd_dir,
    output logic               cmd_ack,
    output logic               res_req,
    output rot_pkg::rot_word_t res_data,
    input  logic               res_ack
);
    import rot_pkg::*;

    logic      in_valid;
    rot_word_t in_data;
    rot_amt_t  in_amt;
    rot_dir_e  in_dir;
    logic      out_valid;
    rot_word_t out_data;
    rot_word_t rd_data;
    logic      empty;
    logic      pop;
    logic      credit_ret;

    rot_cmd_rx cmd_rx_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_req    (cmd_req),
        .cmd_data   (cmd_data),
        .cmd_amt    (cmd_amt),
        .cmd_dir    (cmd_dir),
        .cmd_ack    (cmd_ack),
        .credit_ret (credit_ret),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_amt     (in_amt),
        .in_dir     (in_dir)
    );

    rot_pipe pipe_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_amt    (in_amt),
        .in_dir    (in_dir),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    rot_result_fifo fifo_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (out_valid),
        .wr_data (out_data),
        .pop     (pop),
        .rd_data (rd_data),
        .empty   (empty)
    );

    rot_result_tx result_tx_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .empty      (empty),
        .rd_data    (rd_data),
        .pop        (pop),
        .credit_ret (credit_ret),
        .res_req    (res_req),
        .res_data   (res_data),
        .res_ack    (res_ack)
    );

endmodule

//--- tests/rot_unit_props.sv
// Handshake and FIFO assertions for the rotation unit, bound onto the top level.
`timescale 1ns/1ps

module rot_unit_props (
    input logic               clk,
    input logic               rst_n,
    input logic               cmd_req,
    input logic               cmd_ack,
    input logic               res_req,
    input logic               res_ack,
    input logic               empty,
    input rot_pkg::rot_word_t res_data
);
    int fail_count = 0;                         // Failed assertions so far.

    // The ack follows a request seen on the edge before.
    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_ack) |-> $past(cmd_req))
        else begin
            fail_count++;
            $error("cmd_ack rose while cmd_req was low");
        end

    res_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (res_req && !res_ack) |=> $stable(res_data))
        else begin
            fail_count++;
            $error("res_data changed while res_req waited for res_ack");
        end

    no_req_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        empty |-> !res_req)
        else begin
            fail_count++;
            $error("res_req high while the result FIFO is empty");
        end

endmodule

//--- tests/rot_unit_tb.sv
// Testbench for the rotation unit: drives the command port from pattern and random vectors.
`timescale 1ns/1ps
`include "rot_defines.svh"

module rot_unit_tb;
    import rot_pkg::*;

    localparam int MAX_VEC     = 32;
    localparam int N_RAND      = 64;
    localparam int N_FAST      = 16;
    localparam int N_TAIL      = 4;
    localparam int RESP_RANDOM = 0;
    localparam int RESP_ZERO   = 1;
    localparam int RESP_SLOW   = 2;

    logic      clk;
    logic      rst_n;
    logic      cmd_req;
    rot_word_t cmd_data;
    rot_amt_t  cmd_amt;
    rot_dir_e  cmd_dir;
    logic      cmd_ack;
    logic      res_req;
    rot_word_t res_data;
    logic      res_ack;

    logic [15:0] pat_mem [0:4*MAX_VEC-1];       // Data, amount, direction, expected.
    rot_word_t   rnd_word [N_RAND];
    rot_amt_t    rnd_amt [N_RAND];
    rot_dir_e    rnd_dir [N_RAND];
    rot_word_t   exp_q [$];
    int          seed = 32'h5e9a;
    int          n_vec;
    int          timeout_cycles = 0;
    int          mismatch_count = 0;
    int          fault_count = 0;
    int          cmd_count = 0;
    int          res_count = 0;
    int          resp_mode;
    logic        hold_res;

    rot_unit_top dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd_req  (cmd_req),
        .cmd_data (cmd_data),
        .cmd_amt  (cmd_amt),
        .cmd_dir  (cmd_dir),
        .cmd_ack  (cmd_ack),
        .res_req  (res_req),
        .res_data (res_data),
        .res_ack  (res_ack)
    );

    bind rot_unit_top rot_unit_props props_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd_req  (cmd_req),
        .cmd_ack  (cmd_ack),
        .res_req  (res_req),
        .res_ack  (res_ack),
        .empty    (empty),
        .res_data (res_data)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            mismatch_count++;
            $display("ERR time=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
        end
    endtask

    // Left moves bit i to (i+amt) mod width, right is the inverse.
    function automatic rot_word_t rotate_word(rot_word_t w, rot_amt_t amt, rot_dir_e dir);
        rot_word_t r;
        int        j;
        r = '0;
        for (int i = 0; i < `ROT_WIDTH; i++) begin
            j = (i + int'(amt)) % `ROT_WIDTH;
            if (dir == ROT_LEFT) r[j] = w[i];
            else r[i] = w[j];
        end
        return r;
    endfunction

    task automatic raise_command(input rot_word_t d, input rot_amt_t a, input rot_dir_e dir,
                                 input rot_word_t expected);
        @(negedge clk);
        while (cmd_ack) @(negedge clk);         // Previous handshake must be closed.
        cmd_data = d;
        cmd_amt  = a;
        cmd_dir  = dir;
        cmd_req  = 1'b1;
        exp_q.push_back(expected);
    endtask

    task automatic complete_command();
        while (!cmd_ack) @(negedge clk);
        cmd_req = 1'b0;
        cmd_count++;
    endtask

    task automatic send_command(input rot_word_t d, input rot_amt_t a, input rot_dir_e dir,
                                input rot_word_t expected);
        raise_command(d, a, dir, expected);
        complete_command();
    endtask

    task automatic wait_for_drain();
        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
    endtask

    // Host side of the result port.
    initial begin
        int          delay;
        logic [31:0] r;
        forever begin
            @(negedge clk);
            if (res_req && !res_ack && !hold_res) begin
                r = $random(seed);
                case (resp_mode)
                    RESP_ZERO: delay = 0;
                    RESP_SLOW: delay = 20;
                    default:   delay = int'(r[1:0]);
                endcase
                repeat (delay) @(negedge clk);
                if (exp_q.size() == 0) begin
                    fault_count++;
                    $display("A result word arrived at %0t with no command outstanding", $time);
                end else begin
                    check_value("res_data", exp_q.pop_front(), res_data);
                end
                res_count++;
                res_ack = 1'b1;
                while (res_req) @(negedge clk);
                res_ack = 1'b0;
            end
        end
    end

    initial begin
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the DUT stopped responding", timeout_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int          c0;
        int          r0;
        int          total;
        logic [31:0] r;
        rot_word_t   d;
        clk       = 1'b0;
        rst_n     = 1'b0;
        cmd_req   = 1'b0;
        cmd_data  = '0;
        cmd_amt   = '0;
        cmd_dir   = ROT_RIGHT;
        res_ack   = 1'b0;
        hold_res  = 1'b0;
        resp_mode = RESP_RANDOM;

        for (int k = 0; k < 4 * MAX_VEC; k++) pat_mem[k] = 16'hf000 | 16'(k);
        $readmemh("tests/rot_patterns.txt", pat_mem);
        n_vec = 0;
        while (n_vec < MAX_VEC && pat_mem[4*n_vec+2] <= 16'd1) n_vec++;
        if (n_vec == 0) begin
            fault_count++;
            $display("No vectors were read from the pattern file");
        end
        for (int i = 0; i < N_RAND; i++) begin
            r = $random(seed);
            rnd_word[i] = r[15:0];
            rnd_amt[i]  = r[19:16];
            rnd_dir[i]  = rot_dir_e'(r[20]);
        end
        timeout_cycles = (n_vec + N_RAND + N_FAST + `ROT_FIFO_DEPTH + 1 + N_TAIL) * 40 + 300;

        repeat (5) begin
            @(negedge clk);
            check_value("cmd_ack", 0, cmd_ack);
            check_value("res_req", 0, res_req);
        end
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_value("cmd_ack", 0, cmd_ack);
            check_value("res_req", 0, res_req);
        end

        for (int i = 0; i < n_vec; i++) begin
            send_command(pat_mem[4*i], pat_mem[4*i+1][`ROT_AMT_W-1:0],
                         rot_dir_e'(pat_mem[4*i+2][0]), pat_mem[4*i+3]);
        end
        wait_for_drain();

        for (int i = 0; i < N_RAND; i++) begin
            send_command(rnd_word[i], rnd_amt[i], rnd_dir[i],
                         rotate_word(rnd_word[i], rnd_amt[i], rnd_dir[i]));
        end
        wait_for_drain();

        resp_mode = RESP_ZERO;
        c0 = cmd_count;
        r0 = res_count;
        for (int i = 0; i < N_FAST; i++) begin
            d = 16'(i * 16'h0f1d + 16'h0003);
            send_command(d, rot_amt_t'(i), rot_dir_e'(i[0]),
                         rotate_word(d, rot_amt_t'(i), rot_dir_e'(i[0])));
        end
        wait_for_drain();
        check_value("result count", cmd_count - c0, res_count - r0);

        // Stalled host: the FIFO fills and credits run out.
        hold_res  = 1'b1;
        resp_mode = RESP_SLOW;
        for (int i = 0; i < `ROT_FIFO_DEPTH + 1 + N_TAIL; i++) begin
            d = 16'h8421 ^ 16'(i * 16'h0101);
            if (i == `ROT_FIFO_DEPTH) begin
                raise_command(d, rot_amt_t'(i + 1), ROT_LEFT, rotate_word(d, rot_amt_t'(i + 1), ROT_LEFT));
                repeat (40) begin
                    @(negedge clk);
                    check_value("cmd_ack", 0, cmd_ack);
                end
                hold_res = 1'b0;
                complete_command();
            end else begin
                send_command(d, rot_amt_t'(i + 1), ROT_LEFT, rotate_word(d, rot_amt_t'(i + 1), ROT_LEFT));
            end
        end
        wait_for_drain();

        total = mismatch_count + fault_count + dut_i.props_i.fail_count;
        $display("Summary: %0d value mismatches, %0d other failures, %0d assertion failures",
                 mismatch_count, fault_count, dut_i.props_i.fail_count);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- tests/rot_patterns.txt
// Columns: data, amount, direction (0 right, 1 left), expected result, all in hex.
// One vector per line, applied in order.
1234 0 0 1234
1234 0 1 1234
1234 8 0 3412
1234 8 1 3412
ffff 5 1 ffff
ffff 3 0 ffff
0001 1 1 0002
0001 1 0 8000
8000 f 1 4000
0001 f 0 0002
1234 4 1 2341
1234 4 0 4123
00f0 2 0 003c
00f0 6 1 3c00
a5c3 1 1 4b87
a5c3 7 0 874b
0100 9 1 0002
8001 2 0 6000

//--- filelist.f
+incdir+common
common/rot_pkg.sv
rotator/rot_pipe.sv
rotator/rot_cmd_rx.sv
rtl/rot_result_fifo.sv
rtl/rot_result_tx.sv
rtl/rot_unit_top.sv
tests/rot_unit_props.sv
tests/rot_unit_tb.sv

//--- run.sh
#!/bin/sh
# Builds the rotation unit testbench with Verilator, runs it and checks the log.
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module rot_unit_tb \
    -o rot_unit_sim || { echo "Verilator build failed"; exit 1; }
./obj_dir/rot_unit_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
